//--- Bender.yml
package:
  name: bus_card

sources:
  - include_dirs:
      - .
    files:
      - bus_pkg.sv
      - bus_addr_reg.sv
      - bus_mbu.sv
      - bus_const_store.sv
      - bus_databus.sv
      - bus_card.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_bus_card.sv

//--- bus_addr_reg.sv
`timescale 1ns/1ps

`include "bus_consts.svh"

module bus_addr_reg
   import bus_pkg::*;
(
   input  logic       clk1,
   input  logic       arst_n,
   input  ucode_t     uc,
   input  word_t      ibus_in,
   input  logic [7:0] aext,
   input  fp_sel_t    fp_sel,
   output addr_t      ab,
   output iodev_t     iodev,
   output logic [7:0] fpd
);

   addr_t ar;                             // The 24-bit address register

   //////////////////////////////
   // Address register
   //////////////////////////////

   always_ff @(posedge clk1 or negedge arst_n) begin
      if (!arst_n) begin
         ar <= '0;
      end else if (uc.waddr == `BUS_WADDR_AR) begin
         ar.offset <= ibus_in;            // Low word from the processor
         ar.bank   <= aext;               // Bank of this same cycle
      end
   end

   assign ab = ar;

   //////////////////////////////
   // I/O space decoder
   //////////////////////////////

   always_comb begin
      iodev = '1;                         // Nothing selected
      if (!uc.io_n) begin
         case (ar.offset[9:8])
            `BUS_IO_SYSDEV: iodev.sysdev_n = 1'b0;
            `BUS_IO_DEV1XX: iodev.dev1xx_n = 1'b0;
            `BUS_IO_DEV2XX: iodev.dev2xx_n = 1'b0;
            `BUS_IO_DEV3XX: iodev.dev3xx_n = 1'b0;
            default:        iodev = '1;
         endcase
      end
   end

   // Front panel byte
   always_comb begin
      case (fp_sel)
         FP_AR_LO:  fpd = ar.offset[7:0];
         FP_AR_MID: fpd = ar.offset[15:8];
         FP_AR_HI:  fpd = ar.bank;
         default:   fpd = 8'h00;
      endcase
   end

   // Only one device decode may be live on the backplane
   a_iodev_onehot: assert property (
      @(posedge clk1) disable iff (!arst_n)
      $onehot0(~iodev)
   ) else $error("bus_addr_reg: more than one iodev select low");

endmodule

//--- bus_card.sv
`timescale 1ns/1ps

module bus_card
   import bus_pkg::*;
(
   input  logic       clk1,
   input  logic       arst_n,
   input  ucode_t     uc,
   input  logic [2:0] ir,
   input  word_t      ibus_in,
   output word_t      ibus_out,
   output logic       ibus_oe,
   output addr_t      ab,
   input  word_t      db_in,
   output word_t      db_out,
   output logic       db_oe,
   output logic       w_n,
   input  logic       ws_n,
   output logic       waiting_n,
   input  logic       halt_n,
   output iodev_t     iodev,
   input  fp_sel_t    fp_sel,
   output logic [7:0] fpd
);

   logic [7:0] aext;                      // MBU bank into AR[23:16]
   logic       io_wr;                     // I/O write completes
   word_t      cs_word;
   logic       cs_valid;
   word_t      dr_word;
   logic       dr_valid;

   //////////////////////////////
   // Card blocks
   //////////////////////////////

   bus_addr_reg u_addr_reg (
      .clk1(clk1), .arst_n(arst_n), .uc(uc), .ibus_in(ibus_in), .aext(aext),
      .fp_sel(fp_sel), .ab(ab), .iodev(iodev), .fpd(fpd)
   );

   bus_mbu u_mbu (
      .clk1(clk1), .arst_n(arst_n), .uc(uc), .ir(ir), .ibus_in(ibus_in), .ab(ab),
      .iodev(iodev), .io_wr(io_wr), .db_out(db_out), .aext(aext)
   );

   bus_const_store u_const_store (.uc(uc), .cs_word(cs_word), .cs_valid(cs_valid));

   bus_databus u_databus (
      .clk1(clk1), .arst_n(arst_n), .uc(uc), .ibus_in(ibus_in), .db_in(db_in),
      .ws_n(ws_n), .halt_n(halt_n), .db_out(db_out), .db_oe(db_oe), .w_n(w_n),
      .waiting_n(waiting_n), .io_wr(io_wr), .dr_word(dr_word), .dr_valid(dr_valid)
   );

   // Read windows never overlap so at most one source drives the IBus
   assign ibus_oe  = cs_valid | dr_valid;
   assign ibus_out = cs_valid ? cs_word : (dr_valid ? dr_word : '0);

endmodule

//--- bus_const_store.sv
`timescale 1ns/1ps

`include "bus_consts.svh"

module bus_const_store
   import bus_pkg::*;
(
   input  ucode_t uc,
   output word_t  cs_word,
   output logic   cs_valid
);

   // Eight read addresses from 18 up
   assign cs_valid = (uc.raddr & `BUS_RADDR_CS_MASK) == `BUS_RADDR_CS_BASE;

   //////////////////////////////
   // Constant table
   //////////////////////////////

   always_comb begin
      case (uc.raddr[2:0])
         3'd0:    cs_word = 16'h0000;     // Zero
         3'd1:    cs_word = 16'h0001;     // One
         3'd2:    cs_word = 16'h0002;
         3'd3:    cs_word = 16'h0004;
         3'd4:    cs_word = 16'h0008;     // Vector spacing
         3'd5:    cs_word = 16'h0010;
         3'd6:    cs_word = 16'h8000;     // Sign bit
         3'd7:    cs_word = 16'hFFFF;     // All ones
         default: cs_word = 16'h0000;
      endcase
   end

endmodule

//--- bus_consts.svh
`ifndef BUS_CONSTS_SVH
`define BUS_CONSTS_SVH

//////////////////////////////
// Microcode register addresses
//////////////////////////////

`define BUS_WADDR_AR       5'h02  // IBus write loads AR offset
`define BUS_WADDR_DR       5'h03  // IBus write loads data register
`define BUS_RADDR_DR       5'h03  // IBus read of data register
`define BUS_RADDR_CS_BASE  5'h18  // First of eight constants
`define BUS_RADDR_CS_MASK  5'h18  // Constant store window mask
`define BUS_ACT_MBU_IR     4'h4   // Bank picked by IR[2:0]

//////////////////////////////
// I/O space decode
//////////////////////////////

`define BUS_IO_SYSDEV      2'd0   // Range 000 to 0FF
`define BUS_IO_DEV1XX      2'd1   // Range 100 to 1FF
`define BUS_IO_DEV2XX      2'd2   // Range 200 to 2FF
`define BUS_IO_DEV3XX      2'd3   // Range 300 to 3FF

// MBU registers inside the system device range
`define BUS_MBU_IO_BASE    8'h08  // Bank register 0
`define BUS_MBU_IO_MASK    8'hF8  // Eight bank registers
`define BUS_MBU_IO_CTL     8'h00  // Enable register

`define BUS_TIMEOUT        64     // Wait limit in clocks

`endif

//--- bus_databus.sv
`timescale 1ns/1ps

`include "bus_consts.svh"

module bus_databus
   import bus_pkg::*;
(
   input  logic   clk1,
   input  logic   arst_n,
   input  ucode_t uc,
   input  word_t  ibus_in,
   input  word_t  db_in,
   input  logic   ws_n,
   input  logic   halt_n,
   output word_t  db_out,
   output logic   db_oe,
   output logic   w_n,
   output logic   waiting_n,
   output logic   io_wr,
   output word_t  dr_word,
   output logic   dr_valid
);

   typedef enum logic [1:0] {ST_IDLE, ST_ACTIVE, ST_STRETCH} db_state_t;

   db_state_t st;                         // Sequencer state
   logic      cyc_wr;                     // Current cycle is a write
   logic      cyc_io;                     // Current cycle is in I/O space
   logic      start;                      // New cycle accepted
   logic      done;                       // Cycle ends on this edge
   word_t     dr;                         // Data register

   assign start = (st == ST_IDLE) && halt_n
                  && (!uc.mem_n || !uc.io_n) && (!uc.rd_n || !uc.wen_n);
   assign done  = (st != ST_IDLE) && ws_n; // No wait request sampled

   //////////////////////////////
   // Cycle sequencer
   //////////////////////////////

   always_ff @(posedge clk1 or negedge arst_n) begin
      if (!arst_n) begin
         st        <= ST_IDLE;
         cyc_wr    <= 1'b0;
         cyc_io    <= 1'b0;
         w_n       <= 1'b1;
         db_oe     <= 1'b0;
         waiting_n <= 1'b1;
      end else begin
         case (st)
            ST_IDLE: if (start) begin
               st        <= ST_ACTIVE;
               cyc_wr    <= !uc.wen_n;    // Write wins over read
               cyc_io    <= !uc.io_n;
               w_n       <= uc.wen_n;
               db_oe     <= !uc.wen_n;
               waiting_n <= 1'b0;
            end
            ST_ACTIVE, ST_STRETCH: if (done) begin
               st        <= ST_IDLE;
               w_n       <= 1'b1;         // Release the data bus
               db_oe     <= 1'b0;
               waiting_n <= 1'b1;         // Tells microcode to move on
            end else begin
               st <= ST_STRETCH;          // Wait state
            end
            default: st <= ST_IDLE;
         endcase
      end
   end

   assign io_wr = done && cyc_wr && cyc_io;

   // Data register
   always_ff @(posedge clk1) begin
      if (done && !cyc_wr) begin
         dr <= db_in;                     // Read completes
      end else if (uc.waddr == `BUS_WADDR_DR) begin
         dr <= ibus_in;
      end
   end

   assign db_out   = dr;
   assign dr_word  = dr;
   assign dr_valid = uc.raddr == `BUS_RADDR_DR;

   a_wn_oe: assert property (
      @(posedge clk1) disable iff (!arst_n)
      w_n != db_oe
   ) else $error("bus_databus: w_n and db_oe disagree");

   a_halt_blocks: assert property (
      @(posedge clk1) disable iff (!arst_n)
      (st == ST_IDLE && !halt_n) |=> w_n
   ) else $error("bus_databus: write started while halted");

endmodule

//--- bus_mbu.sv
`timescale 1ns/1ps

`include "bus_consts.svh"

module bus_mbu
   import bus_pkg::*;
(
   input  logic       clk1,
   input  logic       arst_n,
   input  ucode_t     uc,
   input  logic [2:0] ir,
   input  word_t      ibus_in,
   input  addr_t      ab,
   input  iodev_t     iodev,
   input  logic       io_wr,
   input  word_t      db_out,
   output logic [7:0] aext
);

   logic [7:0] bank_q [0:7];              // Bank registers MB0 to MB7
   logic       mbu_en;                    // Banking enabled
   logic       sys_wr;                    // System device write completes
   logic       bank_hit;                  // I/O address in bank window
   logic       ctl_hit;                   // I/O address on enable register
   logic [2:0] bank_idx;                  // Bank used for the next AR load

   //////////////////////////////
   // Register write decode
   //////////////////////////////

   assign sys_wr   = io_wr && !iodev.sysdev_n;
   assign bank_hit = (ab.offset[7:0] & `BUS_MBU_IO_MASK) == `BUS_MBU_IO_BASE;
   assign ctl_hit  = ab.offset[7:0] == `BUS_MBU_IO_CTL;

   always_ff @(posedge clk1 or negedge arst_n) begin
      if (!arst_n) begin
         bank_q <= '{default: 8'h00};     // All banks map to zero
      end else if (sys_wr && bank_hit) begin
         bank_q[ab.offset[2:0]] <= db_out[7:0]; // Only the low byte is wired
      end
   end

   always_ff @(posedge clk1 or negedge arst_n) begin
      if (!arst_n) begin
         mbu_en <= 1'b0;                  // Flat 64K space out of reset
      end else if (sys_wr && ctl_hit) begin
         mbu_en <= db_out[0];
      end
   end

   //////////////////////////////
   // Address extension
   //////////////////////////////

   // IR indexing is for instructions that name their own bank;
   // otherwise the top three address bits pick the bank
   always_comb begin
      if (uc.action == `BUS_ACT_MBU_IR) begin
         bank_idx = ir;
      end else begin
         bank_idx = ibus_in[15:13];
      end
   end

   always_comb begin
      if (mbu_en) begin
         aext = bank_q[bank_idx];
      end else begin
         aext = 8'h00;                    // Disabled MBU gives bank 0
      end
   end

   //////////////////////////////
   // Checks
   //////////////////////////////

   // The sequencer finishes an I/O write only while the microcode
   // still holds the I/O strobe and the write request
   a_io_wr_strobes: assert property (
      @(posedge clk1) disable iff (!arst_n)
      io_wr |-> (!uc.io_n && !uc.wen_n)
   ) else $error("bus_mbu: io_wr outside a held I/O write");

endmodule

//--- bus_pkg.sv
package bus_pkg;

   //////////////////////////////
   // Bus words and addresses
   //////////////////////////////

   typedef logic [15:0] word_t;   // Processor and data bus word

   typedef struct packed {
      logic [7:0] bank;           // AR[23:16] from the MBU
      word_t      offset;         // AR[15:0] from the IBus
   } addr_t;

   //////////////////////////////
   // Microcode and strobes
   //////////////////////////////

   typedef struct packed {
      logic [4:0] raddr;          // IBus read source
      logic [4:0] waddr;          // IBus write destination
      logic [3:0] action;         // Action field
      logic       mem_n;          // Memory space cycle
      logic       io_n;           // I/O space cycle
      logic       rd_n;           // Read request
      logic       wen_n;          // Write request
   } ucode_t;

   // Decoded I/O device selects
   typedef struct packed {
      logic sysdev_n;             // 000 to 0FF
      logic dev1xx_n;             // 100 to 1FF
      logic dev2xx_n;             // 200 to 2FF
      logic dev3xx_n;             // 300 to 3FF
   } iodev_t;

   //////////////////////////////
   // Front panel
   //////////////////////////////

   typedef enum logic [1:0] {
      FP_AR_LO  = 2'd0,           // AR[7:0]
      FP_AR_MID = 2'd1,           // AR[15:8]
      FP_AR_HI  = 2'd2            // AR[23:16]
   } fp_sel_t;

endpackage

//--- tb_bus_card.sv
`timescale 1ns/1ps

`include "bus_consts.svh"

module tb_bus_card
   import bus_pkg::*;
();

   logic       clk1;
   logic       arst_n;
   ucode_t     uc;
   logic [2:0] ir;
   word_t      ibus_in;
   word_t      ibus_out;
   logic       ibus_oe;
   addr_t      ab;
   word_t      db_in;
   word_t      db_out;
   logic       db_oe;
   logic       w_n;
   logic       ws_n;
   logic       waiting_n;
   logic       halt_n;
   iodev_t     iodev;
   fp_sel_t    fp_sel;
   logic [7:0] fpd;

   int          errors;                   // Failed checks
   int          checks;                   // All checks run
   logic [31:0] lfsr_q;                   // Stimulus LFSR state

   bus_card dut0 (.*);

   initial begin
      clk1 = 1'b0;
      forever #50 clk1 = ~clk1;           // 100 ns period
   end

   //////////////////////////////
   // Stimulus source
   //////////////////////////////

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic take_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_q = lfsr_next(lfsr_q);      // One step per bit
         v      = {v[30:0], lfsr_q[0]};
      end
   endtask

   //////////////////////////////
   // Compare tasks
   //////////////////////////////

   task automatic check_word(input string name, input word_t exp, input word_t act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("FAIL %s expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic check_addr(input string name, input addr_t exp, input addr_t act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("FAIL %s expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic check_iodev(input string name, input iodev_t exp, input iodev_t act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("FAIL %s expected %b actual %b", name, exp, act);
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("FAIL %s expected %b actual %b", name, exp, act);
      end
   endtask

   //////////////////////////////
   // Bus drivers
   //////////////////////////////

   task automatic drive_idle();
      uc.raddr  = 5'h00;                  // Reads nothing onto the IBus
      uc.waddr  = 5'h00;
      uc.action = 4'h0;
      uc.mem_n  = 1'b1;
      uc.io_n   = 1'b1;
      uc.rd_n   = 1'b1;
      uc.wen_n  = 1'b1;
   endtask

   task automatic ar_load(input word_t offset, input logic [3:0] act, input logic [2:0] irv);
      @(negedge clk1);
      uc.waddr  = `BUS_WADDR_AR;          // Bank comes from this same cycle
      uc.action = act;
      ir        = irv;
      ibus_in   = offset;
      @(negedge clk1);
      uc.waddr  = 5'h00;
      uc.action = 4'h0;
   endtask

   task automatic dr_load(input word_t data);
      @(negedge clk1);
      uc.waddr = `BUS_WADDR_DR;
      ibus_in  = data;
      @(negedge clk1);
      uc.waddr = 5'h00;
   endtask

   // One memory or I/O cycle with hold wait states and strobes held until waiting_n rises
   task automatic run_cycle(input string name, input logic is_io, input logic is_wr,
                            input int hold, input word_t din, input word_t dexp);
      int   n;
      logic fin;
      n   = 0;
      fin = 1'b0;
      @(negedge clk1);
      uc.mem_n = is_io;
      uc.io_n  = !is_io;
      uc.rd_n  = is_wr;
      uc.wen_n = !is_wr;
      db_in    = din;
      ws_n     = (hold == 0);             // Not looked at on the start edge
      while (!fin && n < `BUS_TIMEOUT) begin
         @(negedge clk1);
         if (waiting_n) begin
            fin = 1'b1;
         end else begin
            check_bit({name, " w_n"}, !is_wr, w_n);
            check_bit({name, " db_oe"}, is_wr, db_oe);
            if (is_wr) begin
               check_word({name, " db_out"}, dexp, db_out);
            end
            ws_n = (n < hold) ? 1'b0 : 1'b1; // Low for the first hold edges
            n++;
         end
      end
      drive_idle();
      ws_n = 1'b1;
      if (!fin) begin
         errors++;
         $display("ERROR %s: waiting_n still low after %0d cycles", name, `BUS_TIMEOUT);
      end else begin
         check_word({name, " latency"}, hold + 1, n);
      end
      check_bit({name, " w_n released"}, 1'b1, w_n);
   endtask

   //////////////////////////////
   // Tests
   //////////////////////////////

   task automatic test_const_store();
      word_t cs_exp [0:7];
      cs_exp = '{16'h0000, 16'h0001, 16'h0002, 16'h0004,
                 16'h0008, 16'h0010, 16'h8000, 16'hFFFF};
      for (int i = 0; i < 8; i++) begin
         @(negedge clk1);
         uc.raddr = `BUS_RADDR_CS_BASE + i;
         #10;
         check_bit("test_const_store ibus_oe", 1'b1, ibus_oe);
         check_word("test_const_store ibus_out", cs_exp[i], ibus_out);
      end
      for (int r = 0; r < 24; r++) begin  // Everything below the window
         if (r != `BUS_RADDR_DR) begin
            @(negedge clk1);
            uc.raddr = r;
            #10;
            check_bit("test_const_store no drive", 1'b0, ibus_oe);
         end
      end
      @(negedge clk1);
      uc.raddr = 5'h00;
   endtask

   task automatic check_fpd(input string name, input fp_sel_t sel, input logic [7:0] exp);
      @(negedge clk1);
      fp_sel = sel;
      #10;
      check_word(name, {8'h00, exp}, {8'h00, fpd});
   endtask

   task automatic test_ar_load();
      logic [31:0] v;
      addr_t       exp;
      for (int k = 0; k < 3; k++) begin
         take_bits(16, v);
         ar_load(v[15:0], 4'h0, 3'd0);
         exp.bank   = 8'h00;              // MBU off since reset
         exp.offset = v[15:0];
         check_addr("test_ar_load ab", exp, ab);
         check_fpd("test_ar_load fpd", FP_AR_LO, exp.offset[7:0]);
         check_fpd("test_ar_load fpd", FP_AR_MID, exp.offset[15:8]);
         check_fpd("test_ar_load fpd", FP_AR_HI, exp.bank);
      end
   endtask

   task automatic test_io_decode();
      logic [31:0] v;
      iodev_t      exp;
      for (int r = 0; r < 4; r++) begin
         take_bits(8, v);
         ar_load({6'b000000, r[1:0], v[7:0]}, 4'h0, 3'd0);
         @(negedge clk1);
         uc.io_n = 1'b0;                  // No rd_n or wen_n, so no bus cycle
         #10;
         exp = 4'hF;
         case (r)
            0: exp.sysdev_n = 1'b0;
            1: exp.dev1xx_n = 1'b0;
            2: exp.dev2xx_n = 1'b0;
            default: exp.dev3xx_n = 1'b0;
         endcase
         check_iodev("test_io_decode", exp, iodev);
         @(negedge clk1);
         uc.io_n = 1'b1;
         #10;
         check_iodev("test_io_decode io_n high", 4'hF, iodev);
      end
   endtask

   task automatic test_bus_write();
      logic [31:0] v;
      logic [31:0] h;
      for (int k = 0; k < 6; k++) begin
         take_bits(16, v);
         take_bits(3, h);
         dr_load(v[15:0]);
         run_cycle("test_bus_write", 1'b0, 1'b1, h % 6, 16'h0000, v[15:0]);
      end
   endtask

   task automatic test_bus_read();
      logic [31:0] v;
      logic [31:0] h;
      for (int k = 0; k < 6; k++) begin
         take_bits(16, v);
         take_bits(3, h);
         run_cycle("test_bus_read", 1'b0, 1'b0, h % 6, v[15:0], 16'h0000);
         @(negedge clk1);
         uc.raddr = `BUS_RADDR_DR;
         #10;
         check_bit("test_bus_read ibus_oe", 1'b1, ibus_oe);
         check_word("test_bus_read ibus_out", v[15:0], ibus_out);
         @(negedge clk1);
         uc.raddr = 5'h00;
      end
   endtask

   task automatic test_mbu_bank();
      logic [7:0]  banks [0:7];
      logic [31:0] v;
      logic [31:0] h;
      word_t       off;
      addr_t       exp;
      for (int k = 0; k < 8; k++) begin   // Fill the bank registers
         take_bits(16, v);
         take_bits(3, h);
         banks[k] = v[7:0];               // Only the low byte lands
         off      = {8'h00, `BUS_MBU_IO_BASE};
         ar_load(off + k, 4'h0, 3'd0);
         dr_load(v[15:0]);
         run_cycle("test_mbu_bank io write", 1'b1, 1'b1, h % 6, 16'h0000, v[15:0]);
      end
      take_bits(16, v);
      ar_load(v[15:0], 4'h0, 3'd0);
      exp.bank   = 8'h00;                 // Still disabled
      exp.offset = v[15:0];
      check_addr("test_mbu_bank disabled", exp, ab);
      ar_load({8'h00, `BUS_MBU_IO_CTL}, 4'h0, 3'd0);
      dr_load(16'h0001);
      run_cycle("test_mbu_bank enable", 1'b1, 1'b1, 0, 16'h0000, 16'h0001);
      for (int j = 0; j < 8; j++) begin   // Bank from IBus bits 15:13
         take_bits(16, v);
         off = {j[2:0], v[12:0]};
         ar_load(off, 4'h0, v[15:13]);
         exp.bank   = banks[j];
         exp.offset = off;
         check_addr("test_mbu_bank by address", exp, ab);
      end
      for (int j = 0; j < 8; j++) begin   // Bank from IR
         take_bits(16, v);
         ar_load(v[15:0], `BUS_ACT_MBU_IR, j[2:0]);
         exp.bank   = banks[j];
         exp.offset = v[15:0];
         check_addr("test_mbu_bank by ir", exp, ab);
         check_fpd("test_mbu_bank fpd", FP_AR_HI, exp.bank);
      end
   endtask

   //////////////////////////////
   // Sequence
   //////////////////////////////

   initial begin
      errors  = 0;
      checks  = 0;
      lfsr_q  = 32'hedfe7645;
      arst_n  = 1'b0;
      drive_idle();
      ir      = 3'd0;
      ibus_in = 16'h0000;
      db_in   = 16'h0000;
      ws_n    = 1'b1;
      halt_n  = 1'b1;                     // Never halted here
      fp_sel  = FP_AR_LO;
      repeat (3) @(posedge clk1);
      @(negedge clk1);
      arst_n = 1'b1;
      check_bit("reset w_n", 1'b1, w_n);
      check_bit("reset waiting_n", 1'b1, waiting_n);
      check_bit("reset db_oe", 1'b0, db_oe);
      check_bit("reset ibus_oe", 1'b0, ibus_oe);
      check_addr("reset ab", '0, ab);
      test_const_store();
      test_ar_load();
      test_io_decode();
      test_bus_write();
      test_bus_read();
      test_mbu_bank();
      $display("checks %0d errors %0d", checks, errors);
      if (errors == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

//--- vlog.f
+incdir+.
bus_pkg.sv
bus_addr_reg.sv
bus_mbu.sv
bus_const_store.sv
bus_databus.sv
bus_card.sv
tb_bus_card.sv
